// ==== logic/memPkg.sv ====
package memPkg;

   ///////////////////////////////////////////////////////////////////////
   // Data and bus word layouts
   ///////////////////////////////////////////////////////////////////////

   // Bits are numbered 0 to 35 from the most significant end
   typedef logic [0:35] data36_t;

   // Address word presented by the bus master
   // Upper 16 bits are flags, low 20 bits are the address
   typedef struct packed {
      logic [0:2]   flags0;
      // Read cycle
      logic         busRead;
      logic         flag4;
      // Write cycle
      logic         busWrite;
      logic [6:9]   flags6;
      // IO space instead of memory
      logic         busIo;
      logic [11:15] flags11;
      logic [16:35] addr;
   } busWord_t;

   ///////////////////////////////////////////////////////////////////////
   // Memory Status Register
   ///////////////////////////////////////////////////////////////////////

   // Status word as the master writes it
   typedef struct packed {
      logic         eh;
      logic         unused1;
      logic         re;
      // Parity error, kept as written
      logic         pe;
      logic         ee;
      logic [5:11]  unused5;
      // Power fail, a zero here clears it
      logic         pf;
      logic [13:27] unused13;
      logic [28:34] fcb;
      // ECC disable, reads back inverted as EE
      logic         ed;
   } msrWrite_t;

   // Status word as the master reads it
   typedef struct packed {
      logic         eh;
      logic         ue;
      logic         re;
      logic         pe;
      logic         ee;
      logic [5:11]  ecp;
      logic         pf;
      logic         rsvd13;
      logic [14:35] era;
   } msrRead_t;

   // Same 36 bits, decoded differently on write and on read
   typedef union packed {
      msrWrite_t wr;
      msrRead_t  rd;
   } msrWord_t;

   // IO address of the status register
   localparam logic [19:0] MSR_IO_ADDR = 20'o100000;

   // Command from the controller to the datapath
   typedef struct packed {
      logic ramWr;
      logic ramRd;
      logic msrWr;
      // Return the status register instead of SSRAM data
      logic selMsr;
   } memCmd_t;

endpackage

// ==== logic/memArray.sv ====
`timescale 1ns/10ps

module memArray #(
   parameter int memAddrBits = 15
) (
   input  logic            clk,
   input  logic [19:0]     ssramAddr,
   input  memPkg::data36_t ssramDataIn,
   input  logic            ssramWr,
   output memPkg::data36_t ssramDataOut
);

   ///////////////////////////////////////////////////////////////////////
   // Synchronous single-port SSRAM model
   ///////////////////////////////////////////////////////////////////////

   // Array of 36-bit words
   memPkg::data36_t ram [0:2**memAddrBits-1];

   // Word select within the array
   logic [memAddrBits-1:0] wordAddr;

   assign wordAddr = ssramAddr[memAddrBits-1:0];

   // One-cycle read, old data returned on a write
   always_ff @(posedge clk) begin
      if (ssramWr) begin
         ram[wordAddr] <= ssramDataIn;
      end
      ssramDataOut <= ram[wordAddr];
   end

   // Controller range check must keep writes inside the array
   assert property (@(posedge clk)
      ssramWr |-> ((ssramAddr >> memAddrBits) == 20'd0))
      else $error("SSRAM write outside the array");

endmodule

// ==== logic/memStatusReg.sv ====
`timescale 1ns/10ps

module memStatusReg (
   input  logic            clk,
   input  logic            arstN,
   input  memPkg::memCmd_t cmd,
   input  memPkg::data36_t busDataIn,
   output memPkg::data36_t msrRead
);

   ///////////////////////////////////////////////////////////////////////
   // Memory Status Register, IO address 100000
   ///////////////////////////////////////////////////////////////////////

   // Write view
   //   bit 3      PE, stored as written
   //   bit 12     PF, a zero clears it, a one is ignored
   //   bit 35     ED, stored inverted as ECC enable
   //   EH, RE and FCB are accepted and dropped
   // Read view
   //   bit 3      PE
   //   bit 4      EE, inverse of the last ED written
   //   bit 12     PF, set by reset
   //   EH, UE, RE, ECP and ERA always zero

   memPkg::msrWord_t wrView;
   memPkg::msrWord_t rdView;

   logic pe;
   logic eccEnable;
   logic pf;

   assign wrView = busDataIn;

   // State bits
   // Reset comes up as after power fail with ECC on
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pe        <= 1'b0;
         eccEnable <= 1'b1;
         pf        <= 1'b1;
      end else if (cmd.msrWr) begin
         pe        <= wrView.wr.pe;
         eccEnable <= !wrView.wr.ed;
         // PF can only be cleared from the bus
         if (!wrView.wr.pf) begin
            pf <= 1'b0;
         end
      end
   end

   // Read-back formatting
   always_comb begin
      rdView       = '0;
      rdView.rd.pe = pe;
      rdView.rd.ee = eccEnable;
      rdView.rd.pf = pf;
   end

   assign msrRead = rdView;

   // Status writes never come with an SSRAM access
   assert property (@(posedge clk) disable iff (!arstN)
      cmd.msrWr |-> cmd.selMsr && !cmd.ramWr && !cmd.ramRd)
      else $error("status write mixed with SSRAM command");

endmodule

// ==== logic/ssramPort.sv ====
`timescale 1ns/10ps

module ssramPort (
   input  logic             clk,
   input  logic             arstN,
   input  memPkg::memCmd_t  cmd,
   input  memPkg::busWord_t busAddr,
   input  memPkg::data36_t  busDataIn,
   input  memPkg::data36_t  ssramDataIn,
   input  memPkg::data36_t  msrRead,
   output logic [19:0]      ssramAddr,
   output memPkg::data36_t  ssramDataOut,
   output logic             ssramWr,
   output memPkg::data36_t  busDataOut
);

   // Held read source for the acknowledge cycle
   logic selMsr;

   ///////////////////////////////////////////////////////////////////////
   // SSRAM pin registers
   ///////////////////////////////////////////////////////////////////////

   // Control side
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         ssramWr <= 1'b0;
         selMsr  <= 1'b0;
      end else begin
         // Write strobe is one cycle, from the command pulse
         ssramWr <= cmd.ramWr;
         // Remember where the read data comes from
         if (cmd.ramRd || cmd.ramWr || cmd.selMsr) begin
            selMsr <= cmd.selMsr;
         end
      end
   end

   // Address and write data
   // Only loaded for memory cycles, IO leaves the SSRAM pins alone
   always_ff @(posedge clk) begin
      if (cmd.ramRd || cmd.ramWr) begin
         ssramAddr <= busAddr.addr;
      end
      if (cmd.ramWr) begin
         ssramDataOut <= busDataIn;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Read data steering
   ///////////////////////////////////////////////////////////////////////

   // SSRAM output is ready one edge after the address,
   // which lands on the acknowledge cycle
   assign busDataOut = selMsr ? msrRead : ssramDataIn;

endmodule

// ==== logic/memCtrl.sv ====
`timescale 1ns/10ps

module memCtrl #(
   parameter int memAddrBits = 15
) (
   input  logic             clk,
   input  logic             arstN,
   input  logic             busReq,
   input  memPkg::busWord_t busAddr,
   output logic             busAck,
   output memPkg::memCmd_t  cmd
);

   // Words behind the SSRAM, one spare bit so a full 20-bit array fits
   localparam logic [20:0] memWords = 21'd1 << memAddrBits;

   // Request is sampled in idle, command is live during issue,
   // acknowledge is registered on the way out of ack
   enum logic [2:0] {
      idle,
      issue,
      ack,
      waitRelease,
      reject
   } state;

   logic            isRead;
   logic            isWrite;
   logic            memHit;
   logic            ioHit;
   memPkg::memCmd_t nextCmd;

   ///////////////////////////////////////////////////////////////////////
   // Request decode
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      isRead  = busAddr.busRead;
      isWrite = busAddr.busWrite;

      // Memory cycle inside the implemented array
      memHit = !busAddr.busIo && (isRead || isWrite) &&
               ({1'b0, busAddr.addr} < memWords);

      // IO cycle, only the status register answers
      ioHit = busAddr.busIo && (isRead || isWrite) &&
              (busAddr.addr == memPkg::MSR_IO_ADDR);

      // Write takes priority if both flags are set
      nextCmd        = '0;
      nextCmd.ramWr  = memHit && isWrite;
      nextCmd.ramRd  = memHit && !isWrite;
      nextCmd.msrWr  = ioHit && isWrite;
      nextCmd.selMsr = ioHit;
   end

   ///////////////////////////////////////////////////////////////////////
   // Cycle sequencer
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state  <= idle;
         cmd    <= '0;
         busAck <= 1'b0;
      end else begin
         // Command and acknowledge are both single-cycle pulses
         cmd    <= '0;
         busAck <= 1'b0;
         case (state)
            idle: begin
               if (busReq) begin
                  if (memHit || ioHit) begin
                     state <= issue;
                     cmd   <= nextCmd;
                  end else begin
                     // Nothing answers, master times out
                     state <= reject;
                  end
               end
            end
            // Datapath acts on the command at the end of this cycle
            issue: state <= ack;
            ack: begin
               state  <= waitRelease;
               busAck <= 1'b1;
            end
            // Master must drop the request before the next one
            waitRelease: begin
               if (!busReq) begin
                  state <= idle;
               end
            end
            reject: begin
               if (!busReq) begin
                  state <= idle;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   // Acknowledge only answers a request that is still held
   assert property (@(posedge clk) disable iff (!arstN)
      $rose(busAck) |-> busReq)
      else $error("busAck rose without busReq");

   // Acknowledge is a one-cycle pulse
   assert property (@(posedge clk) disable iff (!arstN)
      busAck |=> !busAck)
      else $error("busAck held for two cycles");

endmodule

// ==== logic/memTop.sv ====
`timescale 1ns/10ps

module memTop #(
   parameter int memAddrBits = 15
) (
   input  logic             clk,
   input  logic             arstN,
   input  logic             busReq,
   input  memPkg::busWord_t busAddr,
   input  memPkg::data36_t  busDataIn,
   output logic             busAck,
   output memPkg::data36_t  busDataOut
);

   ///////////////////////////////////////////////////////////////////////
   // Internal nets
   ///////////////////////////////////////////////////////////////////////

   // Command from the sequencer
   memPkg::memCmd_t cmd;

   // Status register read-back
   memPkg::data36_t msrRead;

   // SSRAM pins
   logic [19:0]     ssramAddr;
   logic            ssramWr;
   memPkg::data36_t ramWrData;
   memPkg::data36_t ramRdData;

   ///////////////////////////////////////////////////////////////////////
   // Control and datapath
   ///////////////////////////////////////////////////////////////////////

   memCtrl #(
      .memAddrBits (memAddrBits)
   ) ctrl (
      .clk     (clk),
      .arstN   (arstN),
      .busReq  (busReq),
      .busAddr (busAddr),
      .busAck  (busAck),
      .cmd     (cmd)
   );

   memStatusReg msr (
      .clk       (clk),
      .arstN     (arstN),
      .cmd       (cmd),
      .busDataIn (busDataIn),
      .msrRead   (msrRead)
   );

   ssramPort port (
      .clk          (clk),
      .arstN        (arstN),
      .cmd          (cmd),
      .busAddr      (busAddr),
      .busDataIn    (busDataIn),
      .ssramDataIn  (ramRdData),
      .msrRead      (msrRead),
      .ssramAddr    (ssramAddr),
      .ssramDataOut (ramWrData),
      .ssramWr      (ssramWr),
      .busDataOut   (busDataOut)
   );

   // Stands in for the external SSRAM part
   memArray #(
      .memAddrBits (memAddrBits)
   ) ram (
      .clk          (clk),
      .ssramAddr    (ssramAddr),
      .ssramDataIn  (ramWrData),
      .ssramWr      (ssramWr),
      .ssramDataOut (ramRdData)
   );

endmodule

// ==== tb/memChecker.sv ====
`timescale 1ns/10ps

module memChecker (
   input  logic            clk,
   input  logic            arstN,
   input  logic            busReq,
   input  logic            busAck,
   input  memPkg::data36_t busDataOut,
   input  int              testIdx,
   input  logic [3:0]      expOp,
   input  logic            expAck,
   input  memPkg::data36_t expData,
   output int              passCount,
   output int              failCount,
   output int              doneCount
);

   // busAck is registered two edges after the request sample,
   // so an edge sample first sees it high at edge 3
   localparam int ackEdgeExp = 3;
   // Rejected cycles stay silent at least this long
   localparam int quietEdges = 8;

   logic            active;
   int              edgeCount;
   int              ackCount;
   int              ackEdge;
   int              curTest;
   logic [3:0]      curOp;
   logic            curExpAck;
   memPkg::data36_t curExpData;
   memPkg::data36_t rdData;
   logic            good;

   function automatic string opName(input logic [3:0] op);
      case (op)
         4'h0: return "mem read";
         4'h1: return "mem write";
         4'h2: return "io read";
         4'h3: return "io write";
         default: return "unknown op";
      endcase
   endfunction

   // Only reads put data on the bus
   function automatic logic returnsData(input logic [3:0] op);
      return (op == 4'h0) || (op == 4'h2);
   endfunction

   ///////////////////////////////////////////////////////////////////////
   // Verdict for one bus cycle
   ///////////////////////////////////////////////////////////////////////

   task automatic judgeCycle();
      good = 1'b0;
      if (curExpAck) begin
         if (ackCount == 0) begin
            $display("test %0d %s: the memory never acknowledged the request",
                     curTest, opName(curOp));
         end else if (ackCount != 1 || ackEdge != ackEdgeExp) begin
            $display("ERROR at %0t: test %0d %s busAck at edge %0d for %0d cycles, %s",
                     $time, curTest, opName(curOp), ackEdge, ackCount,
                     "expected edge 3 for 1 cycle");
         end else if (returnsData(curOp) && rdData != curExpData) begin
            $display("ERROR at %0t: test %0d %s returned %09h, expected %09h",
                     $time, curTest, opName(curOp), rdData, curExpData);
         end else begin
            good = 1'b1;
         end
      end else begin
         // Unanswered cycles must leave the master to time out
         if (ackCount != 0) begin
            $display("ERROR at %0t: test %0d %s acknowledged at edge %0d, expected none",
                     $time, curTest, opName(curOp), ackEdge);
         end else if (edgeCount < quietEdges) begin
            $display("test %0d %s: request released after %0d cycles, too early to judge",
                     curTest, opName(curOp), edgeCount);
         end else begin
            good = 1'b1;
         end
      end
      if (good) begin
         $display("test %0d %s ok", curTest, opName(curOp));
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Bus watcher
   ///////////////////////////////////////////////////////////////////////

   always @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         active = 1'b0;
         passCount <= 0;
         failCount <= 0;
         doneCount <= 0;
      end else if (!active) begin
         if (busReq) begin
            // Edge 0, the controller samples the request here too
            active     = 1'b1;
            edgeCount  = 0;
            ackCount   = 0;
            ackEdge    = -1;
            curTest    = testIdx;
            curOp      = expOp;
            curExpAck  = expAck;
            curExpData = expData;
            rdData     = '0;
         end else if (busAck) begin
            $display("busAck seen at %0t with no request pending", $time);
            failCount <= failCount + 1;
         end
      end else begin
         edgeCount = edgeCount + 1;
         if (busAck) begin
            ackCount = ackCount + 1;
            if (ackEdge < 0) begin
               ackEdge = edgeCount;
               // Read data is valid while busAck is high
               rdData  = busDataOut;
            end
         end
         // Master has let go, the cycle is over
         if (!busReq) begin
            judgeCycle();
            active = 1'b0;
            if (good) begin
               passCount <= passCount + 1;
            end else begin
               failCount <= failCount + 1;
            end
            doneCount <= doneCount + 1;
         end
      end
   end

endmodule

// ==== tb/memTb.sv ====
`timescale 1ns/10ps

module memTb;

   // Words per line of the input file
   localparam int fieldsPerTest = 5;
   localparam int maxTests      = 64;
   // Edges the master waits for busAck before giving up
   localparam int ackWindow     = 9;
   // Operation code that closes the list
   localparam logic [35:0] endOfList = 36'hf;

   logic             clk;
   logic             arstN;
   logic             busReq;
   memPkg::busWord_t busAddr;
   memPkg::data36_t  busDataIn;
   logic             busAck;
   memPkg::data36_t  busDataOut;

   // Expectations for the checker, driven with the request
   int               testIdx;
   logic [3:0]       expOp;
   logic             expAck;
   memPkg::data36_t  expData;

   int               passCount;
   int               failCount;
   int               doneCount;

   logic [35:0]      stim [0:maxTests*fieldsPerTest-1];
   int               nTests;
   int               cycleLimit;
   int               cycleCount = 0;

   memTop #(
      .memAddrBits (15)
   ) DUT (
      .clk        (clk),
      .arstN      (arstN),
      .busReq     (busReq),
      .busAddr    (busAddr),
      .busDataIn  (busDataIn),
      .busAck     (busAck),
      .busDataOut (busDataOut)
   );

   memChecker monitor (
      .clk        (clk),
      .arstN      (arstN),
      .busReq     (busReq),
      .busAck     (busAck),
      .busDataOut (busDataOut),
      .testIdx    (testIdx),
      .expOp      (expOp),
      .expAck     (expAck),
      .expData    (expData),
      .passCount  (passCount),
      .failCount  (failCount),
      .doneCount  (doneCount)
   );

   // 100 ns clock
   always #50 clk = ~clk;

   // Run limit, 12 cycles per test plus slack for reset
   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
         $display("run stopped at the cycle limit of %0d before all tests finished",
                  cycleLimit);
         $display("tests failed");
         $finish;
      end
   end

   function automatic int countTests();
      int n;
      n = 0;
      while (n < maxTests && stim[n*fieldsPerTest] != endOfList &&
             !$isunknown(stim[n*fieldsPerTest])) begin
         n = n + 1;
      end
      return n;
   endfunction

   ///////////////////////////////////////////////////////////////////////
   // One bus cycle as the master sees it
   ///////////////////////////////////////////////////////////////////////

   task automatic runTest(input int idx);
      int   base;
      int   gap;
      int   waited;
      logic seen;
      base   = idx * fieldsPerTest;
      gap    = int'($urandom % 4);
      waited = 0;
      seen   = 1'b0;
      // At least one edge with busReq low between cycles
      repeat (gap + 1) @(posedge clk);
      busReq    <= 1'b1;
      busAddr   <= stim[base+1];
      busDataIn <= stim[base+2];
      testIdx   <= idx + 1;
      expOp     <= stim[base][3:0];
      expAck    <= stim[base+3][0];
      expData   <= stim[base+4];
      // Hold address and data until busAck or the window runs out
      while (!seen && waited < ackWindow) begin
         @(posedge clk);
         waited = waited + 1;
         seen   = busAck;
      end
      busReq <= 1'b0;
   endtask

   initial begin
      int i;
      clk       = 1'b0;
      arstN     <= 1'b0;
      busReq    <= 1'b0;
      busAddr   <= '0;
      busDataIn <= '0;
      testIdx   <= 0;
      expOp     <= 4'h0;
      expAck    <= 1'b0;
      expData   <= '0;
      void'($urandom(32'h3f7c_1952));
      $readmemh("tb/memInput.txt", stim);
      nTests     = countTests();
      cycleLimit = nTests * 12 + 20;
      // Reset over two rising edges
      repeat (2) @(posedge clk);
      arstN <= 1'b1;
      for (i = 0; i < nTests; i = i + 1) begin
         runTest(i);
      end
      // Last verdict lands once busReq has dropped
      while (doneCount < nTests) begin
         @(posedge clk);
      end
      if (nTests == 0) begin
         $display("no tests were read from tb/memInput.txt");
      end
      $display("%0d tests run, %0d passed, %0d failed", nTests, passCount, failCount);
      if (nTests > 0 && failCount == 0 && passCount == nTests) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// ==== tb/memInput.txt ====
// op addrWord wdata expAck expData, all hex, bit 0 is the MSB of a 36-bit word
// op 0 mem read, 1 mem write, 2 io read, 3 io write, f ends the list
2 102008000 000000000 1 080800000
1 040000000 123456789 1 000000000
1 040000001 2468ace01 1 000000000
0 100000000 000000000 1 123456789
0 100000001 000000000 1 2468ace01
1 040007fff fedcba987 1 000000000
0 100007fff 000000000 1 fedcba987
// Status register, PF clear then PE and ED
3 042008000 000000000 1 000000000
2 102008000 000000000 1 080000000
3 042008000 000800000 1 000000000
2 102008000 000000000 1 080000000
3 042008000 100000000 1 000000000
2 102008000 000000000 1 180000000
3 042008000 100000001 1 000000000
2 102008000 000000000 1 100000000
3 042008000 000000000 1 000000000
2 102008000 000000000 1 080000000
// Word 0 untouched by the status writes
0 100000000 000000000 1 123456789
// No answer expected
0 100008000 000000000 0 000000000
1 04000ffff 000000000 0 000000000
2 102000010 000000000 0 000000000
3 042008001 000000000 0 000000000
0 100000001 000000000 1 2468ace01
f 000000000 000000000 0 000000000

// ==== memTop.f ====
logic/memPkg.sv
logic/memArray.sv
logic/memStatusReg.sv
logic/ssramPort.sv
logic/memCtrl.sv
logic/memTop.sv
tb/memChecker.sv
tb/memTb.sv

// ==== run.sh ====
#!/bin/bash
# Build the memory testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f memTop.f --top-module memTb \
   -Mdir obj_dir -o memSim \
   && ./obj_dir/memSim | tee sim.log \
   || { echo "Verilator build or simulation run failed"; exit 1; }
grep -qx "all tests passed" sim.log \
   && echo "simulation PASSED" \
   || { echo "simulation FAILED"; exit 1; }
